// File: vlog.f
logic/pool_buffer_pkg.sv
logic/frame_write_ctrl.sv
logic/window_read_ctrl.sv
logic/channel_plane.sv
logic/pool_window_buffer.sv
verification/tb_pool_window_buffer.sv

// File: verification/tb_pool_window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pool_window_buffer
    import pool_buffer_pkg::*;
();

    localparam int FRAME_PIXELS = IMAGE_HEIGHT * IMAGE_WIDTH;

    // two frames with input gaps and two read phases fit well inside this
    localparam int TIMEOUT_CYCLES = 6000;

    logic       clk      = 1'b0;
    logic       rst_n    = 1'b0;
    logic       valid_in = 1'b0;
    pixel_vec_t pixel_in = '0;

    logic       valid_out;
    win_index_t win_index;
    logic       win_last;
    pixel_vec_t win_00;
    pixel_vec_t win_01;
    pixel_vec_t win_10;
    pixel_vec_t win_11;

    integer seed;
    int     cycle_count = 0;
    int     drop_count  = 0;

    // frame as accepted by the buffer with one plane per channel
    pixel_t ref_frame [CHANNELS][IMAGE_HEIGHT][IMAGE_WIDTH];
    pixel_t dropped_vals [$];

    // expected state of the registered outputs after the latest edge
    logic       exp_valid     = 1'b0;
    logic       exp_last      = 1'b0;
    win_index_t exp_index     = '0;
    logic       model_reading = 1'b0;
    int         wr_row        = 0;
    int         wr_col        = 0;
    int         rd_cnt        = 0;

    pool_window_buffer i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .pixel_in  (pixel_in),
        .valid_out (valid_out),
        .win_index (win_index),
        .win_last  (win_last),
        .win_00    (win_00),
        .win_01    (win_01),
        .win_10    (win_10),
        .win_11    (win_11)
    );

    always #10 clk = ~clk;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input pixel_t actual, input pixel_t expected, input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %08h, expected %08h",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic check_index(input win_index_t actual, input win_index_t expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b",
                                      $time, what, actual, expected));
        end
    endtask

    // pos 0..3 is top-left, top-right, bottom-left, bottom-right
    function automatic pixel_t expected_pixel(input int ch, input int w, input int pos);
        int top_row;
        int left_col;
        top_row  = 2 * (w / WINDOWS_PER_ROW);
        left_col = 2 * (w % WINDOWS_PER_ROW);
        return ref_frame[ch][top_row + pos / 2][left_col + pos % 2];
    endfunction

    function automatic pixel_t window_pixel(input int ch, input int pos);
        pixel_vec_t bus;
        case (pos)
            0:       bus = win_00;
            1:       bus = win_01;
            2:       bus = win_10;
            default: bus = win_11;
        endcase
        return bus[ch*PIXEL_BITS +: PIXEL_BITS];
    endfunction

    function automatic logic was_dropped(input pixel_t p);
        foreach (dropped_vals[i]) begin
            if (dropped_vals[i] == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // frame data keeps bit 31 clear while read-phase data sets it
    function automatic pixel_t frame_pixel();
        pixel_t r;
        r = $random(seed);
        r[31] = 1'b0;
        return r;
    endfunction

    // tracks which pixels the buffer takes and what it should emit
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reading = 1'b0;
            wr_row = 0;
            wr_col = 0;
            rd_cnt = 0;
            exp_valid = 1'b0;
            exp_last = 1'b0;
            exp_index = '0;
        end else if (model_reading) begin
            exp_valid = 1'b1;
            exp_index = win_index_t'(rd_cnt);
            exp_last = (rd_cnt == WINDOWS_PER_FRAME - 1);
            if (valid_in) begin
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    dropped_vals.push_back(pixel_in[ch*PIXEL_BITS +: PIXEL_BITS]);
                end
            end
            if (exp_last) begin
                model_reading = 1'b0;
                rd_cnt = 0;
            end else begin
                rd_cnt++;
            end
        end else begin
            exp_valid = 1'b0;
            exp_last = 1'b0;
            if (valid_in) begin
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    ref_frame[ch][wr_row][wr_col] = pixel_in[ch*PIXEL_BITS +: PIXEL_BITS];
                end
                if (wr_col == IMAGE_WIDTH - 1) begin
                    wr_col = 0;
                    if (wr_row == IMAGE_HEIGHT - 1) begin
                        wr_row = 0;
                        model_reading = 1'b1;
                    end else begin
                        wr_row++;
                    end
                end else begin
                    wr_col++;
                end
            end
        end
    end

    // compare mid-cycle once the registered outputs have settled
    always @(negedge clk) begin
        pixel_t actual;
        check_bit(valid_out, exp_valid, "valid_out");
        check_bit(win_last, exp_last, "win_last");
        if (exp_valid) begin
            check_index(win_index, exp_index, "win_index");
            for (int ch = 0; ch < CHANNELS; ch++) begin
                for (int pos = 0; pos < 4; pos++) begin
                    actual = window_pixel(ch, pos);
                    check_bit(was_dropped(actual), 1'b0,
                              $sformatf("read-phase value in channel %0d window %0d pixel %0d",
                                        ch, exp_index, pos));
                    check_pixel(actual, expected_pixel(ch, int'(exp_index), pos),
                                $sformatf("channel %0d window %0d pixel %0d",
                                          ch, exp_index, pos));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("timeout, the run did not finish within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    // starts on a falling edge and returns on the one after the last pixel
    task automatic fill_frame(input bit with_gaps);
        int sent;
        sent = 0;
        while (sent < FRAME_PIXELS) begin
            if (with_gaps && (($random(seed) & 3) == 0)) begin
                valid_in = 1'b0;
            end else begin
                valid_in = 1'b1;
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    pixel_in[ch*PIXEL_BITS +: PIXEL_BITS] = frame_pixel();
                end
                sent++;
            end
            @(negedge clk);
        end
        valid_in = 1'b0;
    endtask

    // distinct values on every cycle until the last window shows up
    task automatic flood_read_phase();
        while (!win_last) begin
            valid_in = 1'b1;
            for (int ch = 0; ch < CHANNELS; ch++) begin
                pixel_in[ch*PIXEL_BITS +: PIXEL_BITS] = {4'hf, 4'(ch), 8'h00, 16'(drop_count)};
            end
            drop_count++;
            @(negedge clk);
        end
        valid_in = 1'b0;
    endtask

    task automatic wait_last_window();
        valid_in = 1'b0;
        while (!win_last) begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed = 32'h8672_c2b1;
        rst_n = 1'b0;
        valid_in = 1'b0;
        pixel_in = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        fill_frame(1'b1);
        flood_read_phase();
        // second frame starts right after the read phase
        fill_frame(1'b0);
        wait_last_window();
        repeat (4) @(negedge clk);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/pool_window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module pool_window_buffer
    import pool_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid_in,
    input  pixel_vec_t pixel_in,
    output logic       valid_out,
    output win_index_t win_index,
    output logic       win_last,
    output pixel_vec_t win_00,
    output pixel_vec_t win_01,
    output pixel_vec_t win_10,
    output pixel_vec_t win_11
);

    logic write_en;
    row_t write_row;
    col_t write_col;
    logic reading;
    row_t read_row;
    col_t read_col;
    logic read_done;

    frame_write_ctrl i_write_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .read_done (read_done),
        .write_en  (write_en),
        .write_row (write_row),
        .write_col (write_col),
        .reading   (reading)
    );

    // one read controller serves all channels since they scan in lockstep
    window_read_ctrl i_read_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .reading   (reading),
        .read_row  (read_row),
        .read_col  (read_col),
        .read_done (read_done),
        .valid_out (valid_out),
        .win_index (win_index),
        .win_last  (win_last)
    );

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
        channel_plane i_plane (
            .clk       (clk),
            .rst_n     (rst_n),
            .write_en  (write_en),
            .write_row (write_row),
            .write_col (write_col),
            .pixel_in  (pixel_in[ch*PIXEL_BITS +: PIXEL_BITS]),
            .reading   (reading),
            .read_row  (read_row),
            .read_col  (read_col),
            .win_00    (win_00[ch*PIXEL_BITS +: PIXEL_BITS]),
            .win_01    (win_01[ch*PIXEL_BITS +: PIXEL_BITS]),
            .win_10    (win_10[ch*PIXEL_BITS +: PIXEL_BITS]),
            .win_11    (win_11[ch*PIXEL_BITS +: PIXEL_BITS])
        );
    end

endmodule

`default_nettype wire

// File: logic/channel_plane.sv
`timescale 1ns/1ps
`default_nettype none

module channel_plane
    import pool_buffer_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   write_en,
    input  row_t   write_row,
    input  col_t   write_col,
    input  pixel_t pixel_in,
    input  logic   reading,
    input  row_t   read_row,
    input  col_t   read_col,
    output pixel_t win_00,
    output pixel_t win_01,
    output pixel_t win_10,
    output pixel_t win_11
);

    // one full frame as a register file for the four read ports
    pixel_t frame_mem [IMAGE_HEIGHT][IMAGE_WIDTH];

    row_t   below_row;
    col_t   right_col;
    pixel_t top_left;
    pixel_t top_right;
    pixel_t bottom_left;
    pixel_t bottom_right;

    always_ff @(posedge clk) begin
        if (write_en) begin
            frame_mem[write_row][write_col] <= pixel_in;
        end
    end

    // read_row and read_col are always even, so the neighbours stay in range
    assign below_row = read_row + row_t'(1);
    assign right_col = read_col + col_t'(1);

    assign top_left     = frame_mem[read_row][read_col];
    assign top_right    = frame_mem[read_row][right_col];
    assign bottom_left  = frame_mem[below_row][read_col];
    assign bottom_right = frame_mem[below_row][right_col];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_00 <= '0;
            win_01 <= '0;
            win_10 <= '0;
            win_11 <= '0;
        end else if (reading) begin
            win_00 <= top_left;
            win_01 <= top_right;
            win_10 <= bottom_left;
            win_11 <= bottom_right;
        end
    end

endmodule

`default_nettype wire

// File: logic/window_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module window_read_ctrl
    import pool_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reading,
    output row_t       read_row,
    output col_t       read_col,
    output logic       read_done,
    output logic       valid_out,
    output win_index_t win_index,
    output logic       win_last
);

    // top-left corner of the current window
    row_t       win_row;
    col_t       win_col;
    win_index_t win_cnt;
    logic       pair_end;
    logic       last_window;

    assign pair_end    = (win_col == col_t'(IMAGE_WIDTH - 2));
    assign last_window = pair_end && (win_row == row_t'(IMAGE_HEIGHT - 2));

    assign read_row  = win_row;
    assign read_col  = win_col;
    assign read_done = reading && last_window;

    // scan two columns per cycle, then down a row pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_row <= '0;
            win_col <= '0;
        end else if (reading) begin
            if (pair_end) begin
                win_col <= '0;
                if (last_window) begin
                    win_row <= '0;
                end else begin
                    win_row <= win_row + row_t'(2);
                end
            end else begin
                win_col <= win_col + col_t'(2);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else if (reading) begin
            if (last_window) begin
                win_cnt <= '0;
            end else begin
                win_cnt <= win_cnt + win_index_t'(1);
            end
        end
    end

    // one cycle late to stay in step with the channel window registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            win_index <= '0;
            win_last  <= 1'b0;
        end else begin
            valid_out <= reading;
            win_last  <= read_done;
            if (reading) begin
                win_index <= win_cnt;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_write_ctrl
    import pool_buffer_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic valid_in,
    input  logic read_done,
    output logic write_en,
    output row_t write_row,
    output col_t write_col,
    output logic reading
);

    phase_t phase;
    row_t   row_cnt;
    col_t   col_cnt;
    logic   row_end;
    logic   last_pixel;

    // pixels are only taken while filling the frame
    assign write_en = valid_in && (phase == PHASE_WRITE);

    assign row_end    = (col_cnt == col_t'(IMAGE_WIDTH - 1));
    assign last_pixel = row_end && (row_cnt == row_t'(IMAGE_HEIGHT - 1));

    assign write_row = row_cnt;
    assign write_col = col_cnt;
    assign reading   = (phase == PHASE_READ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PHASE_WRITE;
        end else begin
            case (phase)
                PHASE_WRITE: begin
                    if (write_en && last_pixel) begin
                        phase <= PHASE_READ;
                    end
                end
                PHASE_READ: begin
                    if (read_done) begin
                        phase <= PHASE_WRITE;
                    end
                end
                default: phase <= PHASE_WRITE;
            endcase
        end
    end

    // raster position of the next pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (write_en) begin
            if (row_end) begin
                col_cnt <= '0;
                if (last_pixel) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + row_t'(1);
                end
            end else begin
                col_cnt <= col_cnt + col_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pool_buffer_pkg.sv
`default_nettype none

package pool_buffer_pkg;

    // both frame dimensions must be even for 2x2 pooling
    localparam int IMAGE_WIDTH  = 26;
    localparam int IMAGE_HEIGHT = 34;

    localparam int CHANNELS   = 4;
    localparam int PIXEL_BITS = 32;

    localparam int WINDOWS_PER_ROW   = IMAGE_WIDTH / 2;
    localparam int WINDOWS_PER_FRAME = WINDOWS_PER_ROW * (IMAGE_HEIGHT / 2);

    // coordinate widths
    localparam int ROW_BITS   = $clog2(IMAGE_HEIGHT);
    localparam int COL_BITS   = $clog2(IMAGE_WIDTH);
    localparam int INDEX_BITS = $clog2(WINDOWS_PER_FRAME);

    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // channel 0 in the low bits
    typedef logic [CHANNELS*PIXEL_BITS-1:0] pixel_vec_t;

    typedef logic [ROW_BITS-1:0]   row_t;
    typedef logic [COL_BITS-1:0]   col_t;
    typedef logic [INDEX_BITS-1:0] win_index_t;

    typedef enum logic {
        PHASE_WRITE = 1'b0,
        PHASE_READ  = 1'b1
    } phase_t;

endpackage

`default_nettype wire
